// ==== Makefile ====
# Verilator build and run for the CPU controller testbench

VERILATOR ?= verilator
TOP       ?= cpu_controller_tb
SEED      ?= 1
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation output holds the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/cpu_controller.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module cpu_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             instr_in,
    input  logic [31:0]             status_reg,
    input  logic [6:0]              pc_in,
    output cpu_ctrl_pkg::exec_ctrl_t exec_ctrl,
    output cpu_ctrl_pkg::mem_ctrl_t  mem_ctrl,
    output cpu_ctrl_pkg::wb_ctrl_t   wb_ctrl,
    output logic [1:0]              sel_pc,
    output logic                    load_pc
);
    import cpu_ctrl_pkg::*;

    logic       start;
    logic       stall;
    logic       epoch_ref;
    logic       fetch_epoch;
    instr_u     exec_instr;
    instr_u     mem_instr;
    logic [6:0] exec_pc;
    logic       exec_epoch;
    logic       exec_valid;
    logic       mem_valid;
    logic [1:0] sel_pc_branch;
    stage_tag_t mem_tag;
    stage_tag_t wait_tag;
    stage_tag_t wb_tag;

    // first cycle out of reset loads the reset vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b1;
        end else begin
            start <= 1'b0;
        end
    end

    assign sel_pc  = start ? `RESET_VECTOR_SEL : sel_pc_branch;
    assign load_pc = !stall;

    fetch_epoch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .epoch_ref   (epoch_ref),
        .stall       (stall),
        .fetch_epoch (fetch_epoch)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_in    (instr_in),
        .pc_in       (pc_in),
        .fetch_epoch (fetch_epoch),
        .mem_tag     (mem_tag),
        .wait_tag    (wait_tag),
        .wb_tag      (wb_tag),
        .exec_ctrl   (exec_ctrl),
        .instr_out   (exec_instr),
        .pc_out      (exec_pc),
        .epoch_out   (exec_epoch),
        .valid_out   (exec_valid),
        .stall       (stall)
    );

    memory_unit u_memory (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_in      (exec_instr),
        .pc_in         (exec_pc),
        .epoch_in      (exec_epoch),
        .valid_in      (exec_valid),
        .status_reg    (status_reg),
        .mem_ctrl      (mem_ctrl),
        .sel_pc_branch (sel_pc_branch),
        .epoch_ref     (epoch_ref),
        .instr_out     (mem_instr),
        .valid_out     (mem_valid),
        .mem_tag       (mem_tag)
    );

    load_tail_unit u_load_tail (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr_in (mem_instr),
        .valid_in (mem_valid),
        .wb_ctrl  (wb_ctrl),
        .wait_tag (wait_tag),
        .wb_tag   (wb_tag)
    );

endmodule

// ==== hw/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    // data processing layout
    typedef struct packed {
        logic [3:0] cond;
        logic [2:0] cls;
        logic [3:0] alu;
        logic       s;
        logic [3:0] rn;
        logic [3:0] rd;
        // shift amount, rs in its top four bits
        logic [4:0] imm5;
        logic [1:0] shift_op;
        logic       reg_shift;
        logic [3:0] rm;
    } dp_view_t;

    // load / store layout
    typedef struct packed {
        logic [3:0]  cond;
        logic [2:0]  cls;
        logic        p;
        logic        u;
        logic        b;
        logic        w;
        logic        l;
        logic [3:0]  rn;
        logic [3:0]  rt;
        logic [11:0] imm12;
    } mem_view_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [2:0]  cls;
        logic        link;
        logic [23:0] imm24;
    } br_view_t;

    typedef union packed {
        dp_view_t  dp_view;
        mem_view_t mem_view;
        br_view_t  br_view;
    } instr_u;

    typedef struct packed {
        logic [6:0] opcode;
        logic [3:0] rn;
        logic [3:0] rm;
        logic [3:0] rs;
        logic [4:0] imm5;
        logic [1:0] sel_a_in;
        logic [1:0] sel_b_in;
        logic [1:0] sel_shift_in;
        logic       sel_shift;
        logic       en_a;
        logic       en_b;
        logic       en_s;
        logic [6:0] pc;
    } exec_ctrl_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [1:0]  shift_op;
        logic [11:0] imm12;
        logic [31:0] imm_branch;
        logic        sel_branch_imm;
        logic        sel_a;
        logic        sel_b;
        logic [2:0]  alu_op;
        logic        sel_pre_indexed;
        logic        en_status;
        logic [1:0]  sel_w_addr1;
        logic        w_en1;
        logic        mem_w_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic [3:0] rt;
        logic       w_en_ldr;
    } wb_ctrl_t;

    // per-stage summary for hazard checks in execute
    typedef struct packed {
        logic [3:0] rd_rt;
        logic       is_load;
        logic       writes_reg;
        logic       epoch;
        logic       valid;
    } stage_tag_t;

endpackage

// ==== hw/execute_unit.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module execute_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::instr_u     instr_in,
    input  logic [6:0]               pc_in,
    input  logic                     fetch_epoch,
    input  cpu_ctrl_pkg::stage_tag_t mem_tag,
    input  cpu_ctrl_pkg::stage_tag_t wait_tag,
    input  cpu_ctrl_pkg::stage_tag_t wb_tag,
    output cpu_ctrl_pkg::exec_ctrl_t exec_ctrl,
    output cpu_ctrl_pkg::instr_u     instr_out,
    output logic [6:0]               pc_out,
    output logic                     epoch_out,
    output logic                     valid_out,
    output logic                     stall
);
    import cpu_ctrl_pkg::*;

    instr_u     instr_q;
    logic [6:0] pc_q;
    logic       epoch_q;
    logic       valid_q;
    logic [2:0] cls;
    logic       is_dp_reg;
    logic       is_dp;
    logic       is_mem;
    logic       is_store;
    logic       reg_shift;
    logic [3:0] rn;
    logic [3:0] rm;
    logic [3:0] rs;
    logic       use_rn;
    logic       use_rm;
    logic       use_rs;

    // load still in flight with r as its target
    function automatic logic load_hit(input stage_tag_t tag, input logic [3:0] r);
        return tag.valid && tag.is_load && (tag.rd_rt == r);
    endfunction

    function automatic logic [1:0] fwd_sel(input logic used, input logic [3:0] r,
                                           input stage_tag_t m, input stage_tag_t w);
        logic [1:0] sel;
        sel = 2'b00;
        if (used && m.valid && m.writes_reg && (m.rd_rt == r)) begin
            sel = 2'b01;
        end else if (used && w.valid && w.is_load && (w.rd_rt == r)) begin
            sel = 2'b10;
        end
        return sel;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (!stall) begin
            epoch_q <= fetch_epoch;
            valid_q <= 1'b1;
        end
    end

    // fetch runs two words ahead of execute
    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_q <= instr_in;
            pc_q    <= pc_in - 7'd2;
        end
    end

    assign cls       = instr_q.dp_view.cls;
    assign is_dp_reg = (cls == `CLS_DP_REG);
    assign is_dp     = is_dp_reg || (cls == `CLS_DP_IMM);
    assign is_mem    = (cls == `CLS_MEM);
    assign is_store  = is_mem && !instr_q.mem_view.l;
    assign reg_shift = is_dp_reg && instr_q.dp_view.reg_shift;

    assign rn = instr_q.dp_view.rn;
    // store data leaves on the b operand
    assign rm = is_mem ? instr_q.mem_view.rt : instr_q.dp_view.rm;
    assign rs = instr_q.dp_view.imm5[4:1];

    assign use_rn = valid_q && (is_dp || is_mem);
    assign use_rm = valid_q && (is_dp_reg || is_store);
    assign use_rs = valid_q && reg_shift;

    // load-use: hold until the load reaches write-back
    always_comb begin
        stall = (use_rn && (load_hit(mem_tag, rn) || load_hit(wait_tag, rn))) ||
                (use_rm && (load_hit(mem_tag, rm) || load_hit(wait_tag, rm))) ||
                (use_rs && (load_hit(mem_tag, rs) || load_hit(wait_tag, rs)));
    end

    always_comb begin
        exec_ctrl.opcode       = {instr_q.dp_view.cls, instr_q.dp_view.alu};
        exec_ctrl.rn           = rn;
        exec_ctrl.rm           = rm;
        exec_ctrl.rs           = rs;
        exec_ctrl.imm5         = instr_q.dp_view.imm5;
        exec_ctrl.sel_a_in     = fwd_sel(use_rn && !stall, rn, mem_tag, wb_tag);
        exec_ctrl.sel_b_in     = fwd_sel(use_rm && !stall, rm, mem_tag, wb_tag);
        exec_ctrl.sel_shift_in = fwd_sel(use_rs && !stall, rs, mem_tag, wb_tag);
        exec_ctrl.sel_shift    = reg_shift;
        exec_ctrl.en_a         = use_rn;
        exec_ctrl.en_b         = use_rm;
        exec_ctrl.en_s         = use_rs;
        exec_ctrl.pc           = pc_q;
    end

    assign instr_out = instr_q;
    assign pc_out    = pc_q;
    assign epoch_out = epoch_q;
    // a stalled instruction leaves a bubble behind
    assign valid_out = valid_q && !stall;

endmodule

// ==== hw/fetch_epoch_unit.sv ====
`timescale 1ns/10ps

module fetch_epoch_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic epoch_ref,
    input  logic stall,
    output logic fetch_epoch
);

    logic fetch_tag;
    logic wait_tag;

    // epoch follows the word through fetch and fetch-wait
    // both hold on stall so tag and word stay paired
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_tag <= 1'b0;
            wait_tag  <= 1'b0;
        end else if (!stall) begin
            fetch_tag <= epoch_ref;
            wait_tag  <= fetch_tag;
        end
    end

    assign fetch_epoch = wait_tag;

endmodule

// ==== hw/load_tail_unit.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module load_tail_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::instr_u     instr_in,
    input  logic                     valid_in,
    output cpu_ctrl_pkg::wb_ctrl_t   wb_ctrl,
    output cpu_ctrl_pkg::stage_tag_t wait_tag,
    output cpu_ctrl_pkg::stage_tag_t wb_tag
);
    import cpu_ctrl_pkg::*;

    instr_u     wait_instr;
    instr_u     wb_instr;
    logic       wait_valid;
    logic       wb_valid;
    logic [3:0] rt_q;
    logic       w_en_q;

    function automatic stage_tag_t load_tag(input instr_u instr, input logic valid);
        stage_tag_t tag;
        tag.rd_rt   = instr.mem_view.rt;
        tag.is_load = (instr.mem_view.cls == `CLS_MEM) && instr.mem_view.l;
        // past memory only loads still write the register file
        tag.writes_reg = tag.is_load;
        // squash already folded into valid
        tag.epoch = 1'b0;
        tag.valid = valid;
        return tag;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_valid <= 1'b0;
            wb_valid   <= 1'b0;
            w_en_q     <= 1'b0;
        end else begin
            wait_valid <= valid_in;
            wb_valid   <= wait_valid;
            w_en_q     <= wb_tag.valid && wb_tag.is_load;
        end
    end

    always_ff @(posedge clk) begin
        wait_instr <= instr_in;
        wb_instr   <= wait_instr;
        rt_q       <= wb_instr.mem_view.rt;
    end

    assign wait_tag = load_tag(wait_instr, wait_valid);
    assign wb_tag   = load_tag(wb_instr, wb_valid);

    // register file write port, one cycle behind write-back data
    assign wb_ctrl.rt       = rt_q;
    assign wb_ctrl.w_en_ldr = w_en_q;

endmodule

// ==== hw/memory_unit.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module memory_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::instr_u     instr_in,
    input  logic [6:0]               pc_in,
    input  logic                     epoch_in,
    input  logic                     valid_in,
    input  logic [31:0]              status_reg,
    output cpu_ctrl_pkg::mem_ctrl_t  mem_ctrl,
    output logic [1:0]               sel_pc_branch,
    output logic                     epoch_ref,
    output cpu_ctrl_pkg::instr_u     instr_out,
    output logic                     valid_out,
    output cpu_ctrl_pkg::stage_tag_t mem_tag
);
    import cpu_ctrl_pkg::*;

    instr_u     instr_q;
    logic [6:0] pc_q;
    logic       epoch_q;
    logic       valid_q;
    logic [2:0] cls;
    logic       is_dp;
    logic       is_mem;
    logic       is_br;
    logic       live;
    logic       taken;
    logic       link;
    logic       dp_writes;
    logic [2:0] alu_op;

    // arm condition rule on n z c v
    function automatic logic cond_pass(input logic [3:0] cond, input logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        n = nzcv[3];
        z = nzcv[2];
        c = nzcv[1];
        v = nzcv[0];
        case (cond)
            `COND_EQ: return z;
            `COND_NE: return !z;
            `COND_CS: return c;
            `COND_CC: return !c;
            `COND_MI: return n;
            `COND_PL: return !n;
            `COND_VS: return v;
            `COND_VC: return !v;
            `COND_HI: return c && !z;
            `COND_LS: return !c || z;
            `COND_GE: return n == v;
            `COND_LT: return n != v;
            `COND_GT: return !z && (n == v);
            `COND_LE: return z || (n != v);
            `COND_AL: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic [2:0] alu_map(input logic [3:0] alu);
        case (alu)
            4'b0000: return `ALU_AND;
            4'b0010: return `ALU_SUB;
            4'b0100: return `ALU_ADD;
            4'b1010: return `ALU_CMP;
            4'b1100: return `ALU_ORR;
            4'b1101: return `ALU_MOV;
            default: return `ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            epoch_q   <= 1'b0;
            epoch_ref <= 1'b0;
        end else begin
            valid_q <= valid_in;
            epoch_q <= epoch_in;
            // new epoch marks everything fetched so far as wrong path
            if (taken) begin
                epoch_ref <= !epoch_ref;
            end
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_in;
        pc_q    <= pc_in;
    end

    assign cls    = instr_q.dp_view.cls;
    assign is_dp  = (cls == `CLS_DP_REG) || (cls == `CLS_DP_IMM);
    assign is_mem = (cls == `CLS_MEM);
    assign is_br  = (cls == `CLS_BRANCH);

    assign live = valid_q && (epoch_q == epoch_ref) &&
                  cond_pass(instr_q.dp_view.cond, status_reg[31:28]);

    assign alu_op    = is_dp ? alu_map(instr_q.dp_view.alu) :
                       (is_mem && !instr_q.mem_view.u) ? `ALU_SUB : `ALU_ADD;
    assign dp_writes = is_dp && (alu_op != `ALU_CMP);
    assign link      = is_br && instr_q.br_view.link;
    assign taken     = live && is_br;

    always_comb begin
        mem_ctrl.opcode     = {instr_q.dp_view.cls, instr_q.dp_view.alu};
        mem_ctrl.rn         = instr_q.dp_view.rn;
        mem_ctrl.rd         = instr_q.dp_view.rd;
        mem_ctrl.shift_op   = instr_q.dp_view.shift_op;
        // branch and link carries its return address to lr
        mem_ctrl.imm12      = link ? {5'd0, pc_q + 7'd1} : instr_q.mem_view.imm12;
        mem_ctrl.imm_branch = {{8{instr_q.br_view.imm24[23]}}, instr_q.br_view.imm24};
        mem_ctrl.sel_branch_imm  = is_br;
        mem_ctrl.sel_a           = is_br;
        mem_ctrl.sel_b           = (cls == `CLS_DP_IMM) || is_mem || is_br;
        mem_ctrl.alu_op          = alu_op;
        mem_ctrl.sel_pre_indexed = is_mem && instr_q.mem_view.p;
        mem_ctrl.en_status       = live && is_dp && instr_q.dp_view.s;
        // 00 rd, 01 base rn, 10 lr
        if (link) begin
            mem_ctrl.sel_w_addr1 = 2'b10;
        end else if (is_mem && instr_q.mem_view.w) begin
            mem_ctrl.sel_w_addr1 = 2'b01;
        end else begin
            mem_ctrl.sel_w_addr1 = 2'b00;
        end
        mem_ctrl.w_en1    = live && (dp_writes || link || (is_mem && instr_q.mem_view.w));
        mem_ctrl.mem_w_en = live && is_mem && !instr_q.mem_view.l;
    end

    assign sel_pc_branch = taken ? `PC_BRANCH : `PC_NEXT;

    assign instr_out = instr_q;
    assign valid_out = live;

    always_comb begin
        mem_tag.rd_rt      = instr_q.dp_view.rd;
        mem_tag.is_load    = is_mem && instr_q.mem_view.l;
        mem_tag.writes_reg = dp_writes;
        mem_tag.epoch      = epoch_q;
        mem_tag.valid      = live;
    end

endmodule

// ==== include/cpu_ctrl_consts.svh ====
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// instruction class, bits 27:25
`define CLS_DP_REG 3'b000
`define CLS_DP_IMM 3'b001
`define CLS_MEM    3'b010
`define CLS_BRANCH 3'b101

// condition field, bits 31:28
`define COND_EQ 4'h0
`define COND_NE 4'h1
`define COND_CS 4'h2
`define COND_CC 4'h3
`define COND_MI 4'h4
`define COND_PL 4'h5
`define COND_VS 4'h6
`define COND_VC 4'h7
`define COND_HI 4'h8
`define COND_LS 4'h9
`define COND_GE 4'ha
`define COND_LT 4'hb
`define COND_GT 4'hc
`define COND_LE 4'hd
`define COND_AL 4'he

// alu operation codes
`define ALU_AND 3'd0
`define ALU_SUB 3'd1
`define ALU_ADD 3'd2
`define ALU_ORR 3'd3
`define ALU_MOV 3'd4
`define ALU_CMP 3'd5

// next pc select
`define PC_NEXT   2'd0
`define PC_RESET  2'd1
`define PC_BRANCH 2'd2

`define RESET_VECTOR_SEL `PC_RESET

// condition never, data-processing class, no effect
`define NOP_INSTR 32'hf000_0000

`endif

// ==== project.f ====
+incdir+include
hw/cpu_ctrl_pkg.sv
hw/fetch_epoch_unit.sv
hw/execute_unit.sv
hw/memory_unit.sv
hw/load_tail_unit.sv
hw/cpu_controller.sv
verif/cpu_controller_assert.sv
verif/cpu_controller_tb.sv

// ==== verif/cpu_controller_assert.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module cpu_controller_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic [1:0]              sel_pc,
    input logic                    load_pc,
    input cpu_ctrl_pkg::mem_ctrl_t mem_ctrl,
    input cpu_ctrl_pkg::wb_ctrl_t  wb_ctrl
);

    logic branch;

    assign branch = (sel_pc == `PC_BRANCH);

    // reset vector in the first cycle after reset and never again
    assert property (@(posedge clk) disable iff (!rst_n)
        (sel_pc == `PC_RESET) == !$past(rst_n))
        else $error("sel_pc reset vector select outside the first cycle after reset");

    // load-use stall is at most two cycles
    assert property (@(posedge clk) disable iff (!rst_n)
        !(!load_pc && !$past(load_pc) && !$past(load_pc, 2)))
        else $error("load_pc low for more than two cycles");

    // the three instructions behind a taken branch are wrong path
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_ctrl.mem_w_en |-> !($past(branch) || $past(branch, 2) || $past(branch, 3)))
        else $error("store enabled for a squashed instruction");

    // loads write back three cycles after leaving memory
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_ctrl.w_en_ldr |-> !($past(branch, 4) || $past(branch, 5) || $past(branch, 6)))
        else $error("load write enabled for a squashed instruction");

endmodule

bind cpu_controller cpu_controller_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel_pc   (sel_pc),
    .load_pc  (load_pc),
    .mem_ctrl (mem_ctrl),
    .wb_ctrl  (wb_ctrl)
);

// ==== verif/cpu_controller_tb.sv ====
`timescale 1ns/10ps
`include "cpu_ctrl_consts.svh"

module cpu_controller_tb;
    import cpu_ctrl_pkg::*;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_in;
    logic [31:0] status_reg;
    logic [6:0]  pc_in;
    exec_ctrl_t  exec_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;
    logic [1:0]  sel_pc;
    logic        load_pc;

    int errors;
    int passed;
    int failed;

    cpu_controller UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_in   (instr_in),
        .status_reg (status_reg),
        .pc_in      (pc_in),
        .exec_ctrl  (exec_ctrl),
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl),
        .sel_pc     (sel_pc),
        .load_pc    (load_pc)
    );

    always #50 clk = ~clk;

    // only the fields set in mask are compared
    task automatic check_exec(input string name, input exec_ctrl_t exp, input exec_ctrl_t mask);
        if ((exec_ctrl & mask) !== (exp & mask)) begin
            $display("CHECK FAILED at %0t: %s exec_ctrl expected %h got %h",
                     $time, name, exp & mask, exec_ctrl & mask);
            errors++;
        end
    endtask

    task automatic check_mem(input string name, input mem_ctrl_t exp, input mem_ctrl_t mask);
        if ((mem_ctrl & mask) !== (exp & mask)) begin
            $display("CHECK FAILED at %0t: %s mem_ctrl expected %h got %h",
                     $time, name, exp & mask, mem_ctrl & mask);
            errors++;
        end
    endtask

    task automatic check_wb(input string name, input wb_ctrl_t exp, input wb_ctrl_t mask);
        if ((wb_ctrl & mask) !== (exp & mask)) begin
            $display("CHECK FAILED at %0t: %s wb_ctrl expected %h got %h",
                     $time, name, exp & mask, wb_ctrl & mask);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input logic [1:0] exp_sel, input logic exp_load);
        if (sel_pc !== exp_sel) begin
            $display("CHECK FAILED at %0t: %s sel_pc expected %h got %h",
                     $time, name, exp_sel, sel_pc);
            errors++;
        end
        if (load_pc !== exp_load) begin
            $display("CHECK FAILED at %0t: %s load_pc expected %b got %b",
                     $time, name, exp_load, load_pc);
            errors++;
        end
    endtask

    // pipeline must release the fetch before the next sequence starts
    task automatic wait_load_pc(input string name);
        int n;
        n = 0;
        instr_in = `NOP_INSTR;
        while (!load_pc && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!load_pc) begin
            $display("timeout: load_pc stayed low after test %s", name);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("PASS %s", name);
            passed++;
        end else begin
            $display("FAIL %s", name);
            failed++;
        end
    endtask

    initial begin
        #1ms;
        $display("watchdog expired, simulation hung");
        $display("tests failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          idx;
        int          cyc;
        int          start_errors;
        int          ecyc;
        int          mcyc;
        int          wcyc;
        string       line;
        string       name;
        logic [31:0] words [4];
        logic [31:0] status;
        logic [6:0]  e_op;
        logic [3:0]  e_rn;
        logic [3:0]  e_rm;
        logic [1:0]  e_sa;
        logic [1:0]  e_sb;
        logic        e_ea;
        logic        e_eb;
        logic [2:0]  m_alu;
        logic        m_w;
        logic        m_es;
        logic        m_mw;
        logic [31:0] m_imm;
        logic [3:0]  w_rt;
        logic        w_en;
        logic [31:0] sel_str;
        logic [7:0]  load_str;
        logic [31:0] exec_word;
        logic [6:0]  exec_pc;
        exec_ctrl_t  e_exp;
        exec_ctrl_t  e_mask;
        mem_ctrl_t   m_exp;
        mem_ctrl_t   m_mask;
        wb_ctrl_t    w_exp;
        wb_ctrl_t    w_mask;

        void'($urandom(32'h22324960));
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_in   = `NOP_INSTR;
        status_reg = 32'd0;
        pc_in      = 7'd0;
        exec_word  = `NOP_INSTR;
        exec_pc    = 7'd0;
        errors     = 0;
        passed     = 0;
        failed     = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        start_errors = errors;
        check_sel("reset", `PC_RESET, 1'b1);
        e_exp  = '0;
        e_mask = '0;
        e_mask.en_a = 1'b1;
        e_mask.en_b = 1'b1;
        e_mask.en_s = 1'b1;
        check_exec("reset", e_exp, e_mask);
        m_exp  = '0;
        m_mask = '0;
        m_mask.w_en1     = 1'b1;
        m_mask.mem_w_en  = 1'b1;
        m_mask.en_status = 1'b1;
        check_mem("reset", m_exp, m_mask);
        w_exp  = '0;
        w_mask = '0;
        w_mask.w_en_ldr = 1'b1;
        check_wb("reset", w_exp, w_mask);
        @(negedge clk);
        check_sel("reset", `PC_NEXT, 1'b1);
        report("reset", start_errors);

        fd = $fopen("verif/cpu_controller_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 8 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line,
                    "%s %h %h %h %h %h %d %h %h %h %h %h %b %b %d %h %b %b %b %h %d %h %b %h %b",
                    name, words[0], words[1], words[2], words[3], status,
                    ecyc, e_op, e_rn, e_rm, e_sa, e_sb, e_ea, e_eb,
                    mcyc, m_alu, m_w, m_es, m_mw, m_imm,
                    wcyc, w_rt, w_en, sel_str, load_str);
                if (n != 25) begin
                    $display("malformed test line: %s", line);
                    errors++;
                    continue;
                end
                e_exp  = '0;
                e_mask = '0;
                e_exp.opcode   = e_op;
                e_exp.rn       = e_rn;
                e_exp.rm       = e_rm;
                e_exp.sel_a_in = e_sa;
                e_exp.sel_b_in = e_sb;
                e_exp.en_a     = e_ea;
                e_exp.en_b     = e_eb;
                e_mask.opcode   = '1;
                e_mask.rn       = '1;
                e_mask.rm       = '1;
                e_mask.rs       = '1;
                e_mask.imm5     = '1;
                e_mask.sel_a_in = '1;
                e_mask.sel_b_in = '1;
                e_mask.en_a     = 1'b1;
                e_mask.en_b     = 1'b1;
                e_mask.pc       = '1;
                m_exp  = '0;
                m_mask = '0;
                m_exp.alu_op     = m_alu;
                m_exp.w_en1      = m_w;
                m_exp.en_status  = m_es;
                m_exp.mem_w_en   = m_mw;
                m_exp.imm_branch = m_imm;
                m_mask.alu_op     = '1;
                m_mask.w_en1      = 1'b1;
                m_mask.en_status  = 1'b1;
                m_mask.mem_w_en   = 1'b1;
                m_mask.imm_branch = '1;
                w_exp.rt       = w_rt;
                w_exp.w_en_ldr = w_en;
                w_mask         = '1;

                start_errors = errors;
                idx          = 0;
                status_reg   = status;
                for (cyc = 0; cyc <= 9; cyc++) begin
                    @(negedge clk);
                    if (cyc == ecyc) begin
                        // shift field is bits 11:7, rs its top four
                        e_exp.rs   = exec_word[11:8];
                        e_exp.imm5 = exec_word[11:7];
                        e_exp.pc   = exec_pc - 7'd2;
                        check_exec(name, e_exp, e_mask);
                    end
                    if (cyc == mcyc) begin
                        check_mem(name, m_exp, m_mask);
                    end
                    if (cyc == wcyc) begin
                        check_wb(name, w_exp, w_mask);
                    end
                    if (cyc >= 1 && cyc <= 8) begin
                        check_sel(name, sel_str[4*(8-cyc) +: 2], load_str[8-cyc]);
                    end
                    instr_in = (idx < 4) ? words[idx] : `NOP_INSTR;
                    pc_in    = 7'($urandom);
                    // a word is taken only while fetch is not held
                    if (load_pc) begin
                        idx++;
                        exec_word = instr_in;
                        exec_pc   = pc_in;
                    end
                end
                wait_load_pc(name);
                report(name, start_errors);
            end
            $fclose(fd);
        end

        $display("%0d run, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/cpu_controller_tests.txt ====
# name i0 i1 i2 i3 status | exec: cyc opcode rn rm sel_a sel_b en_a en_b
# mem: cyc alu_op w_en1 en_status mem_w_en imm_branch | wb: cyc rt w_en_ldr | sel_pc cycles 1-8 | load_pc 1-8
dp_add e0913002 f0000000 f0000000 f0000000 00000000 1 04 1 2 0 0 1 1 2 2 1 1 0 ff913002 5 3 0 00000000 11111111
dp_sub_eq 00454006 f0000000 f0000000 f0000000 40000000 1 02 5 6 0 0 1 1 2 1 1 0 0 00454006 5 4 0 00000000 11111111
cond_eq_fail 00454006 f0000000 f0000000 f0000000 00000000 1 02 5 6 0 0 1 1 2 1 0 0 0 00454006 5 4 0 00000000 11111111
cond_gt c0454006 f0000000 f0000000 f0000000 90000000 1 02 5 6 0 0 1 1 2 1 1 0 0 00454006 5 4 0 00000000 11111111
cond_lt b0454006 f0000000 f0000000 f0000000 90000000 1 02 5 6 0 0 1 1 2 1 0 0 0 00454006 5 4 0 00000000 11111111
cond_hi 80454006 f0000000 f0000000 f0000000 20000000 1 02 5 6 0 0 1 1 2 1 1 0 0 00454006 5 4 0 00000000 11111111
cond_vs 60454006 f0000000 f0000000 f0000000 10000000 1 02 5 6 0 0 1 1 2 1 1 0 0 00454006 5 4 0 00000000 11111111
cond_mi 40454006 f0000000 f0000000 f0000000 00000000 1 02 5 6 0 0 1 1 2 1 0 0 0 00454006 5 4 0 00000000 11111111
cond_ne 10454006 f0000000 f0000000 f0000000 00000000 1 02 5 6 0 0 1 1 2 1 1 0 0 00454006 5 4 0 00000000 11111111
cond_ls 90454006 f0000000 f0000000 f0000000 20000000 1 02 5 6 0 0 1 1 2 1 0 0 0 00454006 5 4 0 00000000 11111111
cond_ge a0454006 f0000000 f0000000 f0000000 80000000 1 02 5 6 0 0 1 1 2 1 0 0 0 00454006 5 4 0 00000000 11111111
alu_cmp e1510002 f0000000 f0000000 f0000000 00000000 1 0a 1 2 0 0 1 1 2 5 0 1 0 00510002 5 0 0 00000000 11111111
alu_orr e1813002 f0000000 f0000000 f0000000 00000000 1 0c 1 2 0 0 1 1 2 3 1 0 0 ff813002 5 3 0 00000000 11111111
alu_and e0013002 f0000000 f0000000 f0000000 00000000 1 00 1 2 0 0 1 1 2 0 1 0 0 00013002 5 3 0 00000000 11111111
alu_mov e1a03002 f0000000 f0000000 f0000000 00000000 1 0d 0 2 0 0 1 1 2 4 1 0 0 ffa03002 5 3 0 00000000 11111111
dp_imm e2813005 f0000000 f0000000 f0000000 00000000 1 14 1 5 0 0 1 0 2 2 1 0 0 ff813005 5 3 0 00000000 11111111
fwd_mem e0913002 e0834003 f0000000 f0000000 00000000 2 04 3 3 1 1 1 1 3 2 1 0 0 ff834003 6 4 0 00000000 11111111
fwd_none e0913002 e0814002 f0000000 f0000000 00000000 2 04 1 2 0 0 1 1 2 2 1 1 0 ff913002 5 3 0 00000000 11111111
br_taken ea800010 e0913002 e0913002 e0913002 00000000 1 54 0 0 0 0 0 0 2 2 0 0 0 ff800010 5 0 0 02000000 11111111
br_squash1 ea800010 e0913002 e0913002 e0913002 00000000 1 54 0 0 0 0 0 0 3 2 0 0 0 ff913002 5 0 0 02000000 11111111
br_squash3 ea800010 e0913002 e0913002 e5878004 00000000 1 54 0 0 0 0 0 0 5 2 0 0 0 ff878004 5 0 0 02000000 11111111
br_not_taken 0a800010 e5878004 f0000000 f0000000 00000000 1 54 0 0 0 0 0 0 3 2 0 0 1 ff878004 5 0 0 00000000 11111111
load_use2 e5975004 e0953002 f0000000 f0000000 00000000 4 04 5 2 2 0 1 1 2 2 0 0 0 ff975004 5 5 1 00000000 10011111
load_use1 e5975004 e0913002 e0953002 f0000000 00000000 4 04 5 2 2 0 1 1 3 2 1 1 0 ff913002 5 5 1 00000000 11011111
